//--- mapper_pkg.sv
//##########################################################################
// Shared definitions for the 4x4 task mapper: grid constants, coordinate,
// id, cost and occupancy types, the request and result structs, and the
// coordinate to id conversion
//##########################################################################

`default_nettype none

package mapper_pkg;

  //##########################################################################
  // Grid geometry
  //##########################################################################

  // PEs per side of the cluster, tied to the id encoding below
  localparam int GRID_DIM = 4;
  // NoC id step from one row to the next
  localparam int ID_ROW_STRIDE = 8;
  localparam int NUM_PE = GRID_DIM * GRID_DIM;

  typedef struct packed {
    logic [1:0] row;
    logic [1:0] col;
  } pe_coord_t;

  typedef logic [5:0] pe_id_t;
  typedef logic [3:0] cost_t;
  typedef logic [3:0] idle_cnt_t;

  // Bit index is row * GRID_DIM + col
  typedef logic [NUM_PE-1:0] occ_vec_t;

  //##########################################################################
  // Structs between the blocks
  //##########################################################################

  // Evaluation request, valid is a one-cycle pulse
  typedef struct packed {
    logic      valid;
    logic      root;
    pe_coord_t ref_point;
  } eval_t;

  typedef struct packed {
    logic      free;
    cost_t     cost;
    idle_cnt_t idle;
  } pe_score_t;

  // Winner handed back to the controller
  typedef struct packed {
    logic      valid;
    pe_coord_t coord;
  } map_sel_t;

  typedef struct packed {
    pe_id_t src_id;
    pe_id_t dest_id;
  } map_result_t;

  // NoC id of a PE, row * 8 + col
  function automatic pe_id_t coord_to_id(input pe_coord_t c);
    return pe_id_t'(int'(c.row) * ID_ROW_STRIDE + int'(c.col));
  endfunction

endpackage

`default_nettype wire

//--- design/map_request_ctrl.sv
//##########################################################################
// Request controller: accepts map requests, keeps the occupancy vector
// and the last mapped PE, and issues one evaluation per request
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module map_request_ctrl
  import mapper_pkg::*;
(
  input  logic     clk,
  input  logic     rst_b,
  input  logic     map_req,
  input  logic     root,
  input  map_sel_t sel,
  input  logic     fail,
  output logic     busy,
  output occ_vec_t occ,
  output eval_t    eval
);

  logic      busy_q;
  occ_vec_t  occ_q;
  pe_coord_t last_q;
  pe_coord_t last_next;
  logic      complete;
  logic      accept;

  //##########################################################################
  // Completion handling
  //##########################################################################

  // Either pulse from the selector ends the current request
  assign complete = sel.valid | fail;

  // Busy drops on the completion edge itself
  assign busy = busy_q & ~complete;

  // Chosen PE shows as occupied from the completion edge on
  always_comb begin
    occ = occ_q;
    if (sel.valid) begin
      occ[{sel.coord.row, sel.coord.col}] = 1'b1;
    end
  end

  // A request taken during the done cycle must see the new parent
  assign last_next = sel.valid ? sel.coord : last_q;

  assign accept = map_req & ~busy;

  //##########################################################################
  // State
  //##########################################################################

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      busy_q <= 1'b0;
      occ_q  <= '0;
      last_q <= '0;
    end else begin
      occ_q  <= occ;
      last_q <= last_next;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (complete) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Evaluation pulse one cycle after accept
  // Kind and parent are held until the next accepted request
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      eval <= '0;
    end else begin
      eval.valid <= accept;
      if (accept) begin
        eval.root      <= root;
        eval.ref_point <= last_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/pe_score_cell.sv
//##########################################################################
// Score cell for one PE: free flag, distance cost and the number of idle
// neighbours within OPT_DIST, registered on each evaluation pulse
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module pe_score_cell
  import mapper_pkg::*;
#(
  parameter int ROW       = 0,
  parameter int COL       = 0,
  parameter int OPT_DIST  = 2,
  parameter int SELF_COST = 10
) (
  input  logic      clk,
  input  logic      rst_b,
  input  occ_vec_t  occ,
  input  eval_t     eval,
  output pe_score_t score
);

  localparam int IDX = ROW * GRID_DIM + COL;

  // Mask of the PEs within OPT_DIST of this one, self excluded
  function automatic occ_vec_t calc_nbr_mask();
    occ_vec_t mask;
    int       dr;
    int       dc;
    mask = '0;
    for (int r = 0; r < GRID_DIM; r++) begin
      for (int c = 0; c < GRID_DIM; c++) begin
        dr = (r > ROW) ? r - ROW : ROW - r;
        dc = (c > COL) ? c - COL : COL - c;
        if ((dr + dc) <= OPT_DIST && (dr + dc) != 0) begin
          mask[r * GRID_DIM + c] = 1'b1;
        end
      end
    end
    return mask;
  endfunction

  localparam occ_vec_t NBR_MASK = calc_nbr_mask();

  // Root cost is the distance from the controller at (0,0)
  // The controller's own PE is pushed to the back with SELF_COST
  localparam cost_t ROOT_COST = (ROW == 0 && COL == 0) ? cost_t'(SELF_COST)
                                                       : cost_t'(ROW + COL);

  cost_t     child_cost;
  idle_cnt_t idle_cnt;

  //##########################################################################
  // Child cost and idle count
  //##########################################################################

  always_comb begin
    int dr;
    int dc;
    dr = ROW - int'(eval.ref_point.row);
    dc = COL - int'(eval.ref_point.col);
    if (dr < 0) begin
      dr = -dr;
    end
    if (dc < 0) begin
      dc = -dc;
    end
    child_cost = cost_t'(dr + dc);
  end

  // Idle neighbours are free PEs inside the mask
  assign idle_cnt = idle_cnt_t'($countones(~occ & NBR_MASK));

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      score <= '0;
    end else if (eval.valid) begin
      score.free <= ~occ[IDX];
      score.cost <= eval.root ? ROOT_COST : child_cost;
      score.idle <= idle_cnt;
    end
  end

endmodule

`default_nettype wire

//--- design/pe_select_tree.sv
//##########################################################################
// Selection tree: reduces the sixteen PE scores to one winner and drives
// the done or fail pulse, the result ids and the winner for the controller
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module pe_select_tree
  import mapper_pkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  pe_score_t   scores [NUM_PE],
  input  eval_t       eval,
  output map_sel_t    sel,
  output logic        map_done,
  output logic        map_fail,
  output map_result_t result
);

  // One candidate in the tree
  typedef struct packed {
    logic      found;
    cost_t     cost;
    idle_cnt_t idle;
    pe_coord_t coord;
  } cand_t;

  // Heap layout: node k has children 2k+1 and 2k+2, leaves in PE order
  cand_t node [2*NUM_PE-1];
  cand_t win;
  logic  pend;
  logic  hit;

  // Lower cost first, then more idle neighbours, then the left input
  // The left subtree always holds the lower PE indices
  function automatic cand_t pick(input cand_t a, input cand_t b);
    if (!b.found) begin
      return a;
    end
    if (!a.found) begin
      return b;
    end
    if (b.cost < a.cost) begin
      return b;
    end
    if (b.cost == a.cost && b.idle > a.idle) begin
      return b;
    end
    return a;
  endfunction

  //##########################################################################
  // Reduction
  //##########################################################################

  always_comb begin
    for (int i = 0; i < NUM_PE; i++) begin
      node[NUM_PE-1+i].found     = scores[i].free;
      node[NUM_PE-1+i].cost      = scores[i].cost;
      node[NUM_PE-1+i].idle      = scores[i].idle;
      node[NUM_PE-1+i].coord.row = 2'(i / GRID_DIM);
      node[NUM_PE-1+i].coord.col = 2'(i % GRID_DIM);
    end
    for (int k = NUM_PE - 2; k >= 0; k--) begin
      node[k] = pick(node[2*k+1], node[2*k+2]);
    end
  end

  assign win = node[0];
  assign hit = pend & win.found;

  //##########################################################################
  // Result stage
  //##########################################################################

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      pend     <= 1'b0;
      sel      <= '0;
      map_done <= 1'b0;
      map_fail <= 1'b0;
      result   <= '0;
    end else begin
      // Scores are valid one cycle after the evaluation pulse
      pend      <= eval.valid;
      sel.valid <= hit;
      map_done  <= hit;
      map_fail  <= pend & ~win.found;
      if (hit) begin
        sel.coord     <= win.coord;
        result.src_id <= coord_to_id(win.coord);
        // A root task is its own destination
        result.dest_id <= eval.root ? coord_to_id(win.coord)
                                    : coord_to_id(eval.ref_point);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/task_mapper.sv
//##########################################################################
// Top level of the task mapper: request controller, sixteen PE score
// cells and the selection tree
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module task_mapper
  import mapper_pkg::*;
#(
  parameter int OPT_DIST  = 2,
  parameter int SELF_COST = 10
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic        map_req,
  input  logic        root,
  output logic        busy,
  output logic        map_done,
  output logic        map_fail,
  output map_result_t result
);

  occ_vec_t  occ;
  eval_t     eval;
  map_sel_t  sel;
  pe_score_t scores [NUM_PE];

  map_request_ctrl u_ctrl (
    .clk     (clk),
    .rst_b   (rst_b),
    .map_req (map_req),
    .root    (root),
    .sel     (sel),
    .fail    (map_fail),
    .busy    (busy),
    .occ     (occ),
    .eval    (eval)
  );

  // One score cell per PE, place taken from the loop index
  for (genvar i = 0; i < NUM_PE; i++) begin : g_cell
    pe_score_cell #(
      .ROW       (i / GRID_DIM),
      .COL       (i % GRID_DIM),
      .OPT_DIST  (OPT_DIST),
      .SELF_COST (SELF_COST)
    ) u_cell (
      .clk   (clk),
      .rst_b (rst_b),
      .occ   (occ),
      .eval  (eval),
      .score (scores[i])
    );
  end

  pe_select_tree u_select (
    .clk      (clk),
    .rst_b    (rst_b),
    .scores   (scores),
    .eval     (eval),
    .sel      (sel),
    .map_done (map_done),
    .map_fail (map_fail),
    .result   (result)
  );

endmodule

`default_nettype wire

//--- testbench/task_mapper_checker.sv
//##########################################################################
// Reference model of the mapping rules: predicts each outcome at accept,
// then checks pulse timing, busy and the result ids against the DUT
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module task_mapper_checker
  import mapper_pkg::*;
#(
  parameter int OPT_DIST  = 2,
  parameter int SELF_COST = 10
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic        map_req,
  input  logic        root,
  input  logic        busy,
  input  logic        map_done,
  input  logic        map_fail,
  input  map_result_t result,
  output int          errors
);

  occ_vec_t    model_occ;
  int          last_row;
  int          last_col;
  int          pend_cnt;
  logic        exp_fail;
  map_result_t exp_result;
  int          err_cnt = 0;

  assign errors = err_cnt;

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
    err_cnt++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t: %s", $time, what);
    err_cnt++;
  endtask

  function automatic int manhattan(input int r0, input int c0, input int r1, input int c1);
    return ((r0 > r1) ? r0 - r1 : r1 - r0) + ((c0 > c1) ? c0 - c1 : c1 - c0);
  endfunction

  // Index of the winning free PE, or -1 on a full grid
  function automatic int pick_target(input logic is_root);
    int best;
    int best_cost;
    int best_idle;
    int cost;
    int idle;
    best = -1;
    best_cost = 0;
    best_idle = 0;
    for (int i = 0; i < NUM_PE; i++) begin
      if (!model_occ[i]) begin
        if (is_root) begin
          cost = (i == 0) ? SELF_COST : i / GRID_DIM + i % GRID_DIM;
        end else begin
          cost = manhattan(i / GRID_DIM, i % GRID_DIM, last_row, last_col);
        end
        idle = 0;
        for (int j = 0; j < NUM_PE; j++) begin
          if (j != i && !model_occ[j] &&
              manhattan(i / GRID_DIM, i % GRID_DIM, j / GRID_DIM, j % GRID_DIM) <= OPT_DIST) begin
            idle++;
          end
        end
        // Scan order already favours the lowest id on a full tie
        if (best < 0 || cost < best_cost || (cost == best_cost && idle > best_idle)) begin
          best = i;
          best_cost = cost;
          best_idle = idle;
        end
      end
    end
    return best;
  endfunction

  always @(posedge clk) begin
    int target;
    if (!rst_b) begin
      model_occ  = '0;
      last_row   = 0;
      last_col   = 0;
      pend_cnt   = 0;
      exp_fail   = 1'b0;
      exp_result = '0;
    end else begin
      if (pend_cnt > 0) begin
        pend_cnt--;
        if (pend_cnt == 0) begin
          if (exp_fail && (!map_fail || map_done)) begin
            report_problem("expected a map_fail pulse alone");
          end
          if (!exp_fail && (!map_done || map_fail)) begin
            report_problem("expected a map_done pulse alone");
          end
          if (result.src_id != exp_result.src_id) begin
            report_mismatch("src_id", int'(exp_result.src_id), int'(result.src_id));
          end
          if (result.dest_id != exp_result.dest_id) begin
            report_mismatch("dest_id", int'(exp_result.dest_id), int'(result.dest_id));
          end
          if (busy) begin
            report_problem("busy still high in the completion cycle");
          end
        end else begin
          if (map_done || map_fail) begin
            report_problem("completion pulse came too early");
          end
          if (!busy) begin
            report_problem("busy low while a request is in flight");
          end
        end
      end else if (map_done || map_fail || busy) begin
        report_problem("pulse or busy seen with no request in flight");
      end
      // Accepted request, outcome is due on the third edge from here
      if (map_req && pend_cnt == 0) begin
        target = pick_target(root);
        exp_fail = (target < 0);
        if (target >= 0) begin
          exp_result.src_id = pe_id_t'((target / GRID_DIM) * ID_ROW_STRIDE + target % GRID_DIM);
          exp_result.dest_id = root ? exp_result.src_id
                                    : pe_id_t'(last_row * ID_ROW_STRIDE + last_col);
          model_occ[target] = 1'b1;
          last_row = target / GRID_DIM;
          last_col = target % GRID_DIM;
        end
        pend_cnt = 3;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/task_mapper_props.sv
//##########################################################################
// Concurrent assertions on completion pulses and busy timing, bound to
// the task mapper top level
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module task_mapper_props (
  input logic clk,
  input logic rst_b,
  input logic map_req,
  input logic busy,
  input logic map_done,
  input logic map_fail
);

  logic accept;

  assign accept = map_req & ~busy;

  done_fail_exclusive: assert property (
    @(posedge clk) disable iff (!rst_b) !(map_done && map_fail)
  ) else $error("map_done and map_fail high in the same cycle");

  // Pulse registers on the second edge after accept, sampled on the third
  pulse_latency: assert property (
    @(posedge clk) disable iff (!rst_b) accept |-> ##3 (map_done || map_fail)
  ) else $error("no completion pulse two cycles after an accepted request");

  busy_span: assert property (
    @(posedge clk) disable iff (!rst_b) accept |=> busy ##1 busy ##1 !busy
  ) else $error("busy does not span request to completion");

  busy_after_reset: assert property (
    @(posedge clk) !rst_b |=> !busy
  ) else $error("busy high after reset");

endmodule

bind task_mapper task_mapper_props props_i (
  .clk      (clk),
  .rst_b    (rst_b),
  .map_req  (map_req),
  .busy     (busy),
  .map_done (map_done),
  .map_fail (map_fail)
);

`default_nettype wire

//--- testbench/task_mapper_tb.sv
//##########################################################################
// Testbench top for the task mapper: clock, reset, stimulus table,
// DUT and checker instances, per-test report and closing summary
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module task_mapper_tb
  import mapper_pkg::*;
();

  localparam int OPT_DIST   = 2;
  localparam int SELF_COST  = 10;
  localparam int NUM_TESTS  = 18;
  localparam int WAIT_LIMIT = 20;

  typedef struct packed {
    logic root;
    logic expect_fail;
  } stim_t;

  logic        clk;
  logic        rst_b;
  logic        map_req;
  logic        root;
  logic        busy;
  logic        map_done;
  logic        map_fail;
  map_result_t result;
  int          checker_errors;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        timed_out = 1'b0;

  // Root, fourteen children, a root that fills the grid, then two on a full grid
  stim_t stim_table [NUM_TESTS] = '{
    '{1'b1, 1'b0},
    '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0},
    '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0},
    '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0}, '{1'b0, 1'b0},
    '{1'b1, 1'b0},
    '{1'b0, 1'b1},
    '{1'b1, 1'b1}
  };

  task_mapper #(
    .OPT_DIST  (OPT_DIST),
    .SELF_COST (SELF_COST)
  ) task_mapper_i (
    .clk      (clk),
    .rst_b    (rst_b),
    .map_req  (map_req),
    .root     (root),
    .busy     (busy),
    .map_done (map_done),
    .map_fail (map_fail),
    .result   (result)
  );

  task_mapper_checker #(
    .OPT_DIST  (OPT_DIST),
    .SELF_COST (SELF_COST)
  ) checker_i (
    .clk      (clk),
    .rst_b    (rst_b),
    .map_req  (map_req),
    .root     (root),
    .busy     (busy),
    .map_done (map_done),
    .map_fail (map_fail),
    .result   (result),
    .errors   (checker_errors)
  );

  task automatic expect_equal(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      tb_errors++;
    end
  endtask

  task automatic check_idle_outputs();
    expect_equal("busy", 0, int'(busy));
    expect_equal("map_done", 0, int'(map_done));
    expect_equal("map_fail", 0, int'(map_fail));
    expect_equal("result", 0, int'(result));
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    int   cycles;
    int   errs_before;
    logic got_fail;
    map_req = 1'b0;
    root    = 1'b0;
    rst_b   = 1'b0;
    repeat (2) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    check_idle_outputs();
    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = checker_errors + tb_errors;
      @(posedge clk);
      map_req <= 1'b1;
      root    <= stim_table[t].root;
      @(posedge clk);
      map_req <= 1'b0;
      // Outputs are looked at mid-cycle, away from the rising edge
      cycles = 0;
      @(negedge clk);
      while (!(map_done || map_fail) && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!(map_done || map_fail)) begin
        $display("Test %0d timed out, no map_done or map_fail in %0d cycles", t, WAIT_LIMIT);
        timed_out = 1'b1;
        break;
      end
      got_fail = map_fail;
      expect_equal("map_fail", int'(stim_table[t].expect_fail), int'(got_fail));
      // Checker compares on the edge that ends the completion cycle
      @(negedge clk);
      tests_run++;
      if (checker_errors + tb_errors != errs_before) begin
        tests_failed++;
      end
      $display("test %0d: %s request, %s, src_id=0x%h dest_id=0x%h, %s", t,
               stim_table[t].root ? "root" : "child", got_fail ? "fail" : "done",
               result.src_id, result.dest_id,
               (checker_errors + tb_errors == errs_before) ? "ok" : "mismatch");
    end
    $display("Summary: %0d tests run, %0d failed, %0d checker errors, %0d testbench errors",
             tests_run, tests_failed, checker_errors, tb_errors);
    if (timed_out || checker_errors + tb_errors != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- task_mapper.f
mapper_pkg.sv
design/map_request_ctrl.sv
design/pe_score_cell.sv
design/pe_select_tree.sv
design/task_mapper.sv
testbench/task_mapper_checker.sv
testbench/task_mapper_props.sv
testbench/task_mapper_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= task_mapper_tb
FILELIST  ?= task_mapper.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
